/* filelist.f */
rtl/prot_pkg.sv
rtl/mcu_addr_decode.sv
rtl/prot_lut.sv
rtl/shared_ram.sv
rtl/irq_timer.sv
rtl/mcu_access_ctrl.sv
rtl/prot_top.sv
verification/tb_clock_gen.sv
verification/prot_props.sv
verification/prot_checker.sv
verification/prot_tb.sv

/* rtl/irq_timer.sv */
`timescale 1ns/100ps

module irq_timer (
    input  logic clk,
    input  logic rst,
    input  logic trigger,
    output logic irq_n
);

    logic [7:0] cnt;

    // reload on every mailbox hit, so a repeat access restarts the hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= 8'd0;
        end else if (trigger) begin
            cnt <= 8'(prot_pkg::irq_hold);
        end else if (cnt != 8'd0) begin
            cnt <= cnt - 8'd1;
        end
    end

    // low from the cycle after trigger for irq_hold cycles
    assign irq_n = (cnt == 8'd0);

endmodule

/* rtl/mcu_access_ctrl.sv */
`timescale 1ns/100ps

module mcu_access_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          game_id,
    input  logic                main_cs,
    input  prot_pkg::mcu_req_t  req,
    input  logic                req_valid,
    output logic                req_ready,
    output prot_pkg::mcu_rsp_t  rsp,
    output logic                rsp_valid,
    input  prot_pkg::region_e   region,
    input  logic [1:0]          bac_func,
    output logic [10:0]         shd_addr,
    output logic [7:0]          shd_wdata,
    output logic                shd_we,
    input  logic [7:0]          shd_rdata,
    output logic                prot_wr,
    output logic [7:0]          prot_wdata,
    input  logic [7:0]          prot_rdata,
    output logic                rom_cs,
    output logic [15:0]         rom_addr,
    input  logic                rom_ok,
    input  logic [7:0]          rom_data,
    output logic                bac_valid,
    output prot_pkg::bac_req_t  bac_req
);

    logic              accept;
    logic              wr;
    logic              rd;
    logic              rom_rd;
    logic              rom_done;
    logic              bac_hit;
    logic [10:0]       local_addr;
    logic [7:0]        work_mem [0:2047];
    logic [7:0]        work_rdata;
    logic [7:0]        rom_q;
    prot_pkg::region_e rsp_region;

    // no mcu bus cycle while the main cpu is on the shared ram
    // and none while a rom fetch is still out
    assign req_ready = !main_cs && !rom_cs;
    assign accept    = req_valid && req_ready;
    assign wr        = accept && req.we;
    assign rd        = accept && !req.we;
    assign rom_rd    = rd && (region == prot_pkg::region_rom);
    assign rom_done  = rom_cs && rom_ok;

    // work and shared ram are both 2 KB deep
    assign local_addr = req.addr.page.offset[10:0];

    // shared ram port b
    assign shd_addr  = local_addr;
    assign shd_wdata = req.wdata;
    assign shd_we    = wr && (region == prot_pkg::region_shared);

    // protection latch
    assign prot_wr    = wr && (region == prot_pkg::region_prot);
    assign prot_wdata = req.wdata;

    // tile controller only fitted on the hippodrome board
    assign bac_hit = accept && (region == prot_pkg::region_bac)
                     && (game_id == prot_pkg::game_hippo);

    // mcu work ram, read data kept until the next accepted read
    always_ff @(posedge clk) begin
        if (wr && (region == prot_pkg::region_work)) begin
            work_mem[local_addr] <= req.wdata;
        end
        if (rd) begin
            work_rdata <= work_mem[local_addr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            rsp_valid <= 1'b0;
            bac_valid <= 1'b0;
        end else begin
            // local reads answer next cycle, rom reads the cycle after rom_ok
            rsp_valid <= (rd && !rom_rd) || rom_done;
            bac_valid <= bac_hit;
            if (rom_rd) begin
                rom_cs <= 1'b1;
            end else if (rom_ok) begin
                rom_cs <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // region of the read in flight, stays put while rom is pending
        if (rd) begin
            rsp_region <= region;
        end
        if (rom_rd) begin
            rom_addr <= req.addr.page.offset;
        end
        if (rom_done) begin
            rom_q <= rom_data;
        end
        if (bac_hit) begin
            bac_req.mode_sel <= (bac_func == 2'd0);
            bac_req.sft_sel  <= (bac_func == 2'd1);
            bac_req.map_sel  <= (bac_func == 2'd2);
            bac_req.word     <= req.addr.tile.word;
            // even byte drives lane 0, odd byte lane 1
            bac_req.dsn      <= {~req.addr.tile.bsel, req.addr.tile.bsel};
            bac_req.wdata    <= req.wdata;
            bac_req.we       <= req.we;
        end
    end

    // response data, tile reads have no read-back and float
    always_comb begin
        case (rsp_region)
            prot_pkg::region_work:   rsp.rdata = work_rdata;
            prot_pkg::region_shared: rsp.rdata = shd_rdata;
            prot_pkg::region_prot:   rsp.rdata = prot_rdata;
            prot_pkg::region_rom:    rsp.rdata = rom_q;
            default:                 rsp.rdata = prot_pkg::open_bus;
        endcase
    end

endmodule

/* rtl/mcu_addr_decode.sv */
`timescale 1ns/100ps

module mcu_addr_decode (
    input  prot_pkg::mcu_addr_u addr,
    input  logic [1:0]          game_id,
    output prot_pkg::region_e   region,
    output logic [1:0]          bac_func
);

    always_comb begin
        region = prot_pkg::region_none;
        if (addr.page.bank == prot_pkg::bank_rom) begin
            // program rom, both variants
            region = prot_pkg::region_rom;
        end else if (addr.page.bank == prot_pkg::bank_local) begin
            // lower 8 KB window is work ram on both boards
            if (!addr.page.offset[13]) begin
                region = prot_pkg::region_work;
            end else if (game_id == prot_pkg::game_std) begin
                // upper window reaches the shared ram only on the standard board
                region = prot_pkg::region_shared;
            end
        end else if (game_id == prot_pkg::game_hippo) begin
            case (addr.page.bank)
                prot_pkg::bank_shared_hippo: begin
                    region = prot_pkg::region_shared;
                end
                prot_pkg::bank_prot: begin
                    region = prot_pkg::region_prot;
                end
                prot_pkg::bank_bac: begin
                    // func 3 has no select line on the tile chip
                    if (addr.tile.func != 2'd3) begin
                        region = prot_pkg::region_bac;
                    end
                end
                default: begin
                    region = prot_pkg::region_none;
                end
            endcase
        end
    end

    // mode, sft or map select, only meaningful in the bac region
    assign bac_func = addr.tile.func;

endmodule

/* rtl/prot_lut.sv */
`timescale 1ns/100ps

module prot_lut (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] wdata,
    output logic [7:0] rdata
);

    logic [7:0] latch_q;

    // byte last written by the mcu
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch_q <= 8'h00;
        end else if (wr_en) begin
            latch_q <= wdata;
        end
    end

    // very short table, the game only probes two values
    always_comb begin
        if (latch_q == prot_pkg::lut_key_a) begin
            rdata = prot_pkg::lut_val_a;
        end else if (latch_q == prot_pkg::lut_key_b) begin
            rdata = prot_pkg::lut_val_b;
        end else begin
            rdata = 8'h00;
        end
    end

endmodule

/* rtl/prot_pkg.sv */
package prot_pkg;

    // game variants selected by game_id
    localparam logic [1:0] game_std   = 2'd0;
    localparam logic [1:0] game_hippo = 2'd1;

    // mcu address banks, bits 20:16 of the mcu address
    localparam logic [4:0] bank_rom          = 5'h00;
    localparam logic [4:0] bank_local        = 5'h1f;
    localparam logic [4:0] bank_shared_hippo = 5'h18;
    localparam logic [4:0] bank_bac          = 5'h1a;
    localparam logic [4:0] bank_prot         = 5'h1d;

    // main cpu writes or reads here to interrupt the mcu
    localparam logic [10:0] mailbox_addr = 11'h7ff;
    // irq low time in clk cycles
    localparam int irq_hold = 254;

    // the only two keys the protection chip is known to answer
    localparam logic [7:0] lut_key_a = 8'h45;
    localparam logic [7:0] lut_val_a = 8'h4e;
    localparam logic [7:0] lut_key_b = 8'h92;
    localparam logic [7:0] lut_val_b = 8'h15;

    // read value of an undecoded location
    localparam logic [7:0] open_bus = 8'hff;

    // flat 64 KB pages
    typedef struct packed {
        logic [4:0]  bank;
        logic [15:0] offset;
    } mcu_page_t;

    // tile controller view, 16-bit words seen through an 8-bit bus
    typedef struct packed {
        logic [4:0] bank;
        logic [2:0] pad;
        logic [1:0] func;
        logic [9:0] word;
        logic       bsel;
    } mcu_tile_t;

    typedef union packed {
        mcu_page_t page;
        mcu_tile_t tile;
    } mcu_addr_u;

    typedef enum logic [2:0] {
        region_none,
        region_rom,
        region_work,
        region_shared,
        region_prot,
        region_bac
    } region_e;

    typedef struct packed {
        mcu_addr_u  addr;
        logic [7:0] wdata;
        logic       we;
    } mcu_req_t;

    typedef struct packed {
        logic [7:0] rdata;
    } mcu_rsp_t;

    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } main_req_t;

    // dsn lanes are active low
    typedef struct packed {
        logic       mode_sel;
        logic       map_sel;
        logic       sft_sel;
        logic [9:0] word;
        logic [1:0] dsn;
        logic [7:0] wdata;
        logic       we;
    } bac_req_t;

endpackage

/* rtl/prot_top.sv */
`timescale 1ns/100ps

module prot_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          game_id,
    // main cpu port
    input  logic                main_cs,
    input  prot_pkg::main_req_t main_req,
    output logic [7:0]          main_rdata,
    // mcu bus
    input  prot_pkg::mcu_req_t  mcu_req,
    input  logic                mcu_req_valid,
    output logic                mcu_req_ready,
    output logic                mcu_rsp_valid,
    output prot_pkg::mcu_rsp_t  mcu_rsp,
    // mcu program rom
    output logic                rom_cs,
    output logic [15:0]         rom_addr,
    input  logic                rom_ok,
    input  logic [7:0]          rom_data,
    // tile controller
    output logic                bac_valid,
    output prot_pkg::bac_req_t  bac_req,
    output logic                irq_n
);

    prot_pkg::region_e region;
    logic [1:0]        bac_func;
    logic [10:0]       shd_addr;
    logic [7:0]        shd_wdata;
    logic              shd_we;
    logic [7:0]        shd_rdata;
    logic              prot_wr;
    logic [7:0]        prot_wdata;
    logic [7:0]        prot_rdata;

    mcu_addr_decode i_decode (
        .addr     (mcu_req.addr),
        .game_id  (game_id),
        .region   (region),
        .bac_func (bac_func)
    );

    mcu_access_ctrl i_access (
        .clk        (clk),
        .rst        (rst),
        .game_id    (game_id),
        .main_cs    (main_cs),
        .req        (mcu_req),
        .req_valid  (mcu_req_valid),
        .req_ready  (mcu_req_ready),
        .rsp        (mcu_rsp),
        .rsp_valid  (mcu_rsp_valid),
        .region     (region),
        .bac_func   (bac_func),
        .shd_addr   (shd_addr),
        .shd_wdata  (shd_wdata),
        .shd_we     (shd_we),
        .shd_rdata  (shd_rdata),
        .prot_wr    (prot_wr),
        .prot_wdata (prot_wdata),
        .prot_rdata (prot_rdata),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .bac_valid  (bac_valid),
        .bac_req    (bac_req)
    );

    prot_lut i_lut (
        .clk   (clk),
        .rst   (rst),
        .wr_en (prot_wr),
        .wdata (prot_wdata),
        .rdata (prot_rdata)
    );

    // port a main cpu, port b mcu
    shared_ram i_shared (
        .clk     (clk),
        .a_addr  (main_req.addr),
        .a_wdata (main_req.wdata),
        .a_we    (main_cs && main_req.we),
        .a_rdata (main_rdata),
        .b_addr  (shd_addr),
        .b_wdata (shd_wdata),
        .b_we    (shd_we),
        .b_rdata (shd_rdata)
    );

    // any main access to the mailbox byte pings the mcu
    irq_timer i_irq (
        .clk     (clk),
        .rst     (rst),
        .trigger (main_cs && (main_req.addr == prot_pkg::mailbox_addr)),
        .irq_n   (irq_n)
    );

endmodule

/* rtl/shared_ram.sv */
`timescale 1ns/100ps

module shared_ram (
    input  logic        clk,
    input  logic [10:0] a_addr,
    input  logic [7:0]  a_wdata,
    input  logic        a_we,
    output logic [7:0]  a_rdata,
    input  logic [10:0] b_addr,
    input  logic [7:0]  b_wdata,
    input  logic        b_we,
    output logic [7:0]  b_rdata
);

    logic [7:0] mem [0:2047];

    // both ports share clk, so one process owns the array
    always_ff @(posedge clk) begin
        // port a, main cpu side
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
        // port b, mcu side
        // never writes together with port a since the mcu stalls on main_cs
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
        b_rdata <= mem[b_addr];
    end

endmodule

/* verification/prot_checker.sv */
`timescale 1ns/100ps

module prot_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          game_id,
    input  logic                main_cs,
    input  prot_pkg::main_req_t main_req,
    input  logic [7:0]          main_rdata,
    input  prot_pkg::mcu_req_t  mcu_req,
    input  logic                mcu_req_valid,
    input  logic                mcu_req_ready,
    input  logic                mcu_rsp_valid,
    input  prot_pkg::mcu_rsp_t  mcu_rsp,
    input  logic                rom_cs,
    input  logic [15:0]         rom_addr,
    input  logic                rom_ok,
    input  logic                bac_valid,
    input  prot_pkg::bac_req_t  bac_req,
    input  logic                irq_n,
    output int                  err_count,
    output int                  rsp_pending
);

    // one expected mcu response, known is low for never written bytes
    typedef struct packed {
        logic              known;
        prot_pkg::region_e rgn;
        logic [7:0]        data;
    } rsp_exp_t;

    logic [7:0]         work_m [0:2047];
    bit                 work_k [0:2047];
    logic [7:0]         shd_m [0:2047];
    bit                 shd_k [0:2047];
    logic [7:0]         latch_m;
    rsp_exp_t           rsp_q [$];
    bit                 rsp_due;
    bit                 rom_busy;
    logic [15:0]        rom_exp_addr;
    bit                 main_rd_due;
    bit                 main_exp_known;
    logic [7:0]         main_exp;
    bit                 bac_due;
    prot_pkg::bac_req_t bac_exp;
    int                 low_left;
    int                 errors = 0;
    int                 pending = 0;

    assign err_count   = errors;
    assign rsp_pending = pending;

    // board memory map per game variant
    function automatic prot_pkg::region_e region_of(prot_pkg::mcu_addr_u a, logic [1:0] g);
        prot_pkg::region_e r;
        r = prot_pkg::region_none;
        case (a.page.bank)
            prot_pkg::bank_rom: r = prot_pkg::region_rom;
            prot_pkg::bank_local: begin
                if (!a.page.offset[13]) begin
                    r = prot_pkg::region_work;
                end else if (g == prot_pkg::game_std) begin
                    r = prot_pkg::region_shared;
                end
            end
            prot_pkg::bank_shared_hippo: begin
                if (g == prot_pkg::game_hippo) r = prot_pkg::region_shared;
            end
            prot_pkg::bank_prot: begin
                if (g == prot_pkg::game_hippo) r = prot_pkg::region_prot;
            end
            // func 3 selects nothing on the tile chip
            prot_pkg::bank_bac: begin
                if (g == prot_pkg::game_hippo && a.tile.func != 2'd3) r = prot_pkg::region_bac;
            end
            default: r = prot_pkg::region_none;
        endcase
        return r;
    endfunction

    function automatic logic [7:0] lut_of(logic [7:0] key);
        if (key == prot_pkg::lut_key_a) return prot_pkg::lut_val_a;
        if (key == prot_pkg::lut_key_b) return prot_pkg::lut_val_b;
        return 8'h00;
    endfunction

    function automatic string test_name(prot_pkg::region_e r);
        case (r)
            prot_pkg::region_work:   return "work_ram";
            prot_pkg::region_shared: return "shared_ram";
            prot_pkg::region_prot:   return "protection";
            prot_pkg::region_rom:    return "rom";
            default:                 return "open_bus";
        endcase
    endfunction

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic push_rsp(input bit known, input prot_pkg::region_e r, input logic [7:0] d);
        rsp_exp_t e;
        e.known = known;
        e.rgn   = r;
        e.data  = d;
        rsp_q.push_back(e);
    endtask

    task automatic reset_model();
        latch_m = 8'h00;
        rsp_q.delete();
        rsp_due     = 1'b0;
        rom_busy    = 1'b0;
        main_rd_due = 1'b0;
        bac_due     = 1'b0;
        low_left    = 0;
        pending     = 0;
    endtask

    // outputs of the cycle that ends at the coming rising edge
    task automatic check_outputs();
        rsp_exp_t e;
        if (mcu_req_ready !== (!main_cs && !rom_busy)) begin
            report("req_ready", !main_cs && !rom_busy, mcu_req_ready);
        end
        if (rom_cs !== rom_busy) report("rom_cs", rom_busy, rom_cs);
        if (rom_busy && rom_ok && rom_addr !== rom_exp_addr) begin
            report("rom_addr", rom_exp_addr, rom_addr);
        end
        if (mcu_rsp_valid !== rsp_due) report("rsp_valid", rsp_due, mcu_rsp_valid);
        if (mcu_rsp_valid === 1'b1) begin
            if (rsp_q.size() == 0) begin
                $display("mcu response arrived with no read outstanding");
                errors++;
            end else begin
                e = rsp_q.pop_front();
                if (e.known && mcu_rsp.rdata !== e.data) begin
                    report(test_name(e.rgn), e.data, mcu_rsp.rdata);
                end
            end
        end
        if (main_rd_due && main_exp_known && main_rdata !== main_exp) begin
            report("main_read", main_exp, main_rdata);
        end
        if (bac_valid !== bac_due) begin
            report("bac_valid", bac_due, bac_valid);
        end else if (bac_due && bac_req !== bac_exp) begin
            report("bac_req", bac_exp, bac_req);
        end
        if (irq_n !== (low_left == 0)) report("irq_n", low_left == 0, irq_n);
    endtask

    // effect of the inputs taken at the coming rising edge
    task automatic update_model();
        prot_pkg::region_e rgn;
        logic [15:0]       off;
        logic [10:0]       idx;
        bit                accept;
        accept      = mcu_req_valid && mcu_req_ready;
        rsp_due     = 1'b0;
        main_rd_due = 1'b0;
        bac_due     = 1'b0;
        // rom data answers the cycle after rom_ok
        if (rom_busy && rom_ok) begin
            rom_busy = 1'b0;
            rsp_due  = 1'b1;
        end
        // any mailbox hit starts the full low time again
        if (main_cs && main_req.addr == prot_pkg::mailbox_addr) begin
            low_left = prot_pkg::irq_hold;
        end else if (low_left > 0) begin
            low_left--;
        end
        if (main_cs && main_req.we) begin
            shd_m[main_req.addr] = main_req.wdata;
            shd_k[main_req.addr] = 1'b1;
        end else if (main_cs) begin
            main_rd_due    = 1'b1;
            main_exp       = shd_m[main_req.addr];
            main_exp_known = shd_k[main_req.addr];
        end
        if (accept) begin
            off = mcu_req.addr.page.offset;
            idx = off[10:0];
            rgn = region_of(mcu_req.addr, game_id);
            case (rgn)
                prot_pkg::region_work: begin
                    if (mcu_req.we) begin
                        work_m[idx] = mcu_req.wdata;
                        work_k[idx] = 1'b1;
                    end else begin
                        push_rsp(work_k[idx], rgn, work_m[idx]);
                    end
                end
                prot_pkg::region_shared: begin
                    if (mcu_req.we) begin
                        shd_m[idx] = mcu_req.wdata;
                        shd_k[idx] = 1'b1;
                    end else begin
                        push_rsp(shd_k[idx], rgn, shd_m[idx]);
                    end
                end
                prot_pkg::region_prot: begin
                    if (mcu_req.we) latch_m = mcu_req.wdata;
                    else push_rsp(1'b1, rgn, lut_of(latch_m));
                end
                prot_pkg::region_rom: begin
                    // rom fills byte = low offset byte xor high offset byte
                    if (!mcu_req.we) begin
                        push_rsp(1'b1, rgn, off[7:0] ^ off[15:8]);
                        rom_busy     = 1'b1;
                        rom_exp_addr = off;
                    end
                end
                default: begin
                    // tile and unmapped reads float
                    if (!mcu_req.we) push_rsp(1'b1, rgn, prot_pkg::open_bus);
                end
            endcase
            if (!mcu_req.we && rgn != prot_pkg::region_rom) rsp_due = 1'b1;
            if (rgn == prot_pkg::region_bac) begin
                bac_due          = 1'b1;
                bac_exp.mode_sel = (mcu_req.addr.tile.func == 2'd0);
                bac_exp.sft_sel  = (mcu_req.addr.tile.func == 2'd1);
                bac_exp.map_sel  = (mcu_req.addr.tile.func == 2'd2);
                bac_exp.word     = mcu_req.addr.tile.word;
                // active low lane, byte select picks the lane
                bac_exp.dsn      = 2'b11;
                bac_exp.dsn[mcu_req.addr.tile.bsel] = 1'b0;
                bac_exp.wdata    = mcu_req.wdata;
                bac_exp.we       = mcu_req.we;
            end
        end
        pending = rsp_q.size();
    endtask

    // falling edge sits between input drive and the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            check_outputs();
            update_model();
        end
    end

endmodule

/* verification/prot_props.sv */
`timescale 1ns/100ps

module prot_props (
    input logic                clk,
    input logic                rst,
    input prot_pkg::mcu_req_t  mcu_req,
    input logic                mcu_req_valid,
    input logic                mcu_req_ready,
    input logic                rom_cs,
    input logic                rom_ok,
    input logic                main_cs,
    input prot_pkg::main_req_t main_req,
    input logic                irq_n
);

    int   fail_cnt = 0;
    logic trigger;

    // main access to the mailbox byte
    assign trigger = main_cs && (main_req.addr == prot_pkg::mailbox_addr);

    // a stalled request stays on the bus unchanged
    req_hold: assert property (@(posedge clk) disable iff (rst)
        mcu_req_valid && !mcu_req_ready |=> mcu_req_valid && $stable(mcu_req))
        else begin
            $error("mcu request changed while stalled");
            fail_cnt++;
        end

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs)
        else begin
            $error("rom_cs dropped before rom_ok");
            fail_cnt++;
        end

    irq_start: assert property (@(posedge clk) disable iff (rst)
        trigger |=> !irq_n)
        else begin
            $error("irq_n not low after a mailbox access");
            fail_cnt++;
        end

    // no retrigger for irq_hold cycles, so the line must be back high
    irq_max: assert property (@(posedge clk) disable iff (rst)
        trigger ##1 (!trigger) [*prot_pkg::irq_hold] |=> irq_n)
        else begin
            $error("irq_n held low beyond the hold time");
            fail_cnt++;
        end

endmodule

/* verification/prot_tb.sv */
`timescale 1ns/100ps

module prot_tb;

    // requests per phase and the run limit derived from them
    localparam int n_req       = 300;
    localparam int n_phase     = 2;
    localparam int cycle_limit = n_phase * (n_req * 8 + prot_pkg::irq_hold * 4);

    logic                clk;
    logic                rst;
    logic [1:0]          game_id;
    logic                main_cs;
    prot_pkg::main_req_t main_req;
    logic [7:0]          main_rdata;
    prot_pkg::mcu_req_t  mcu_req;
    logic                mcu_req_valid;
    logic                mcu_req_ready;
    logic                mcu_rsp_valid;
    prot_pkg::mcu_rsp_t  mcu_rsp;
    logic                rom_cs;
    logic [15:0]         rom_addr;
    logic                rom_ok;
    logic [7:0]          rom_data;
    logic                bac_valid;
    prot_pkg::bac_req_t  bac_req;
    logic                irq_n;
    int                  chk_errors;
    int                  rsp_pending;
    int                  total;
    int                  cycle_cnt = 0;
    bit                  mcu_running;

    tb_clock_gen i_clk (
        .clk (clk),
        .rst (rst)
    );

    prot_top i_dut (.*);

    prot_checker i_chk (
        .clk           (clk),
        .rst           (rst),
        .game_id       (game_id),
        .main_cs       (main_cs),
        .main_req      (main_req),
        .main_rdata    (main_rdata),
        .mcu_req       (mcu_req),
        .mcu_req_valid (mcu_req_valid),
        .mcu_req_ready (mcu_req_ready),
        .mcu_rsp_valid (mcu_rsp_valid),
        .mcu_rsp       (mcu_rsp),
        .rom_cs        (rom_cs),
        .rom_addr      (rom_addr),
        .rom_ok        (rom_ok),
        .bac_valid     (bac_valid),
        .bac_req       (bac_req),
        .irq_n         (irq_n),
        .err_count     (chk_errors),
        .rsp_pending   (rsp_pending)
    );

    bind prot_top prot_props i_props (
        .clk           (clk),
        .rst           (rst),
        .mcu_req       (mcu_req),
        .mcu_req_valid (mcu_req_valid),
        .mcu_req_ready (mcu_req_ready),
        .rom_cs        (rom_cs),
        .rom_ok        (rom_ok),
        .main_cs       (main_cs),
        .main_req      (main_req),
        .irq_n         (irq_n)
    );

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // mix of every region with low offsets so reads hit earlier writes
    function automatic prot_pkg::mcu_req_t rand_req();
        prot_pkg::mcu_req_t r;
        r.wdata            = 8'($urandom);
        r.we               = 1'($urandom_range(0, 1));
        r.addr.page.offset = 16'($urandom_range(0, 15));
        case ($urandom_range(0, 6))
            0: begin
                r.addr.page.bank   = prot_pkg::bank_rom;
                r.addr.page.offset = 16'($urandom);
            end
            1: r.addr.page.bank = prot_pkg::bank_local;
            2: begin
                r.addr.page.bank      = prot_pkg::bank_local;
                r.addr.page.offset[13] = 1'b1;
            end
            3: r.addr.page.bank = prot_pkg::bank_shared_hippo;
            4: begin
                r.addr.page.bank = prot_pkg::bank_prot;
                case ($urandom_range(0, 2))
                    0: r.wdata = prot_pkg::lut_key_a;
                    1: r.wdata = prot_pkg::lut_key_b;
                    default: r.wdata = 8'($urandom);
                endcase
            end
            5: begin
                r.addr.page.bank   = prot_pkg::bank_bac;
                r.addr.page.offset = 16'($urandom);
            end
            default: r.addr.page.bank = 5'($urandom);
        endcase
        return r;
    endfunction

    // hold the request until a cycle with ready high
    task automatic send_mcu(input prot_pkg::mcu_req_t r);
        bit taken;
        taken         = 1'b0;
        mcu_req       = r;
        mcu_req_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = mcu_req_ready;
            next_cycle();
        end
        mcu_req_valid = 1'b0;
    endtask

    task automatic main_access(input logic [10:0] a, input logic we, input logic [7:0] d);
        main_cs        = 1'b1;
        main_req.addr  = a;
        main_req.we    = we;
        main_req.wdata = d;
        next_cycle();
        main_cs = 1'b0;
    endtask

    // main cpu busy about a quarter of the time and now and then on the mailbox
    task automatic main_traffic();
        while (mcu_running) begin
            next_cycle();
            main_cs        = ($urandom_range(0, 3) == 0);
            main_req.addr  = 11'($urandom_range(0, 15));
            main_req.we    = 1'($urandom_range(0, 1));
            main_req.wdata = 8'($urandom);
            if ($urandom_range(0, 31) == 0) main_req.addr = prot_pkg::mailbox_addr;
        end
        main_cs = 1'b0;
    endtask

    task automatic run_phase(input logic [1:0] g);
        game_id     = g;
        mcu_running = 1'b1;
        fork
            begin
                repeat (n_req) begin
                    send_mcu(rand_req());
                    if ($urandom_range(0, 3) == 0) next_cycle();
                end
                mcu_running = 1'b0;
            end
            main_traffic();
        join
        // wait until every mcu read has its response
        while (rsp_pending != 0) next_cycle();
        // irq hold then a restart halfway and then let it run out
        main_access(prot_pkg::mailbox_addr, 1'b0, 8'h00);
        repeat (100) next_cycle();
        main_access(prot_pkg::mailbox_addr, 1'b1, 8'($urandom));
        repeat (prot_pkg::irq_hold + 4) next_cycle();
    endtask

    // rom answers 0 to 5 cycles after rom_cs with low byte xor high byte
    initial begin
        int delay;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            next_cycle();
            if (rom_cs) begin
                delay = $urandom_range(0, 5);
                repeat (delay) next_cycle();
                rom_ok   = 1'b1;
                rom_data = rom_addr[7:0] ^ rom_addr[15:8];
                next_cycle();
                rom_ok = 1'b0;
            end
        end
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run still going after %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h1906));
        game_id       = prot_pkg::game_std;
        main_cs       = 1'b0;
        main_req      = '0;
        mcu_req       = '0;
        mcu_req_valid = 1'b0;
        mcu_running   = 1'b0;
        @(negedge rst);
        next_cycle();
        run_phase(prot_pkg::game_std);
        run_phase(prot_pkg::game_hippo);
        total = chk_errors + i_dut.i_props.fail_cnt;
        $display("errors %0d: checker %0d, assertions %0d",
                 total, chk_errors, i_dut.i_props.fail_cnt);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over the first two rising edges, released just after the second
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule
